// ==== Bender.yml ====
package:
  name: axis_trunc

sources:
  # design sources in compile order
  - logic/trunc_pkg.sv
  - logic/axis_trunc_core.sv
  - logic/trunc_stats.sv
  - logic/trunc_wb_regs.sv
  - logic/axis_trunc_top.sv

  # testbench sources
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/axis_trunc_assertions.sv
      - verification/axis_trunc_tb.sv

// ==== flist.f ====
logic/trunc_pkg.sv
logic/axis_trunc_core.sv
logic/trunc_stats.sv
logic/trunc_wb_regs.sv
logic/axis_trunc_top.sv
verification/tb_clk_gen.sv
verification/axis_trunc_assertions.sv
verification/axis_trunc_tb.sv

// ==== logic/axis_trunc_core.sv ====
/*
 * AXI4-Stream truncation core
 * counts the bytes of each packet, marks the beat holding the
 * last allowed byte as tlast with a trimmed keep mask, and
 * swallows the rest of the packet at one beat per cycle
 */

`timescale 1ns/1ns
`default_nettype none

module axis_trunc_core
   import trunc_pkg::*;
#(
   // when set, byte 0 of a beat sits in the top keep bit
   parameter bit BIGENDIAN = 1'b0
) (
   input  wire          axi4s_in,
   input  wire          rst_n,

   input  wire axis_beat_t  in_beat,
   input  wire          in_valid,
   output logic         in_ready,

   output axis_beat_t   out_beat,
   output logic         out_valid,
   input  wire          out_ready,

   input  wire          trunc_enable,
   input  wire byte_len_t   trunc_length,

   output trunc_event_t trunc_event
);

   // wide enough to hold a full beat count of DATA_BYTES
   localparam int CNT_W = $clog2(DATA_BYTES) + 1;

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   // number of valid bytes in a beat
   function automatic logic [CNT_W-1:0] count_ones(input keep_t keep);
      logic [CNT_W-1:0] total;
      total = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         total = total + CNT_W'(keep[i]);
      end
      return total;
   endfunction

   // keep only the first nbytes bytes of the beat in stream order
   function automatic keep_t trim_keep(input keep_t keep, input logic [CNT_W-1:0] nbytes);
      keep_t trimmed;
      trimmed = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         if (i < nbytes) begin
            if (BIGENDIAN) begin
               trimmed[DATA_BYTES-1-i] = keep[DATA_BYTES-1-i];
            end else begin
               trimmed[i] = keep[i];
            end
         end
      end
      return trimmed;
   endfunction

   // --------------------------------------------------
   // packet state
   // --------------------------------------------------

   // bytes already accepted in the current packet, zero on a first beat
   byte_len_t        byte_count;
   logic             first_beat;
   // limit and enable captured with the first beat of the packet
   logic             lat_enable;
   byte_len_t        lat_length;
   // set once any byte of the current packet has been dropped
   logic             pkt_trunc;

   logic             cur_enable;
   byte_len_t        cur_length;
   logic             limit_on;
   logic [CNT_W-1:0] beat_bytes;
   byte_len_t        remaining;
   logic             pass_beat;
   logic             force_last;
   logic             accepted;
   byte_len_t        beat_dropped;
   logic [16:0]      next_count;

   // the first beat decides with the live register values, later beats with the latched copy
   assign cur_enable = first_beat ? trunc_enable : lat_enable;
   assign cur_length = first_beat ? trunc_length : lat_length;
   assign limit_on   = cur_enable && (cur_length != '0);

   assign beat_bytes = count_ones(in_beat.tkeep);
   assign remaining  = cur_length - byte_count;

   // a beat passes while the limit has not yet been reached
   assign pass_beat  = !limit_on || (byte_count < cur_length);
   // this beat holds byte L, so it ends the output packet
   assign force_last = limit_on && pass_beat && (remaining <= byte_len_t'(beat_bytes));

   // --------------------------------------------------
   // stream path, no registers between input and output
   // --------------------------------------------------

   always_comb begin
      out_beat = in_beat;
      if (force_last) begin
         out_beat.tlast = 1'b1;
         // remaining fits in CNT_W bits here since it is at most beat_bytes
         out_beat.tkeep = trim_keep(in_beat.tkeep, remaining[CNT_W-1:0]);
      end
   end

   assign out_valid = in_valid && pass_beat;
   // dropped beats are always taken so the tail drains under back-pressure
   assign in_ready  = pass_beat ? out_ready : 1'b1;
   assign accepted  = in_valid && in_ready;

   // bytes lost on this beat, either the whole beat or the part cut off by the trim
   always_comb begin
      if (!pass_beat) begin
         beat_dropped = byte_len_t'(beat_bytes);
      end else if (force_last) begin
         beat_dropped = byte_len_t'(beat_bytes) - remaining;
      end else begin
         beat_dropped = '0;
      end
   end

   always_comb begin
      trunc_event.pkt_done  = accepted && in_beat.tlast;
      trunc_event.truncated = accepted && in_beat.tlast && (pkt_trunc || (beat_dropped != '0));
      trunc_event.dropped   = accepted ? beat_dropped : '0;
   end

   // --------------------------------------------------
   // byte counter and per-packet latches
   // --------------------------------------------------

   assign next_count = {1'b0, byte_count} + 17'(beat_bytes);

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         byte_count <= '0;
         first_beat <= 1'b1;
         lat_enable <= 1'b0;
         lat_length <= '0;
         pkt_trunc  <= 1'b0;
      end else if (accepted) begin
         first_beat <= in_beat.tlast;
         if (first_beat) begin
            lat_enable <= trunc_enable;
            lat_length <= trunc_length;
         end
         if (in_beat.tlast) begin
            byte_count <= '0;
            pkt_trunc  <= 1'b0;
         end else begin
            // saturate so a very long packet never wraps back into the pass region
            byte_count <= next_count[16] ? '1 : next_count[15:0];
            if (beat_dropped != '0) begin
               pkt_trunc <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/axis_trunc_top.sv ====
/*
 * AXI4-Stream packet truncator, top level
 * joins the truncation core, the statistics counters and
 * the Wishbone register slave
 */

`timescale 1ns/1ns
`default_nettype none

module axis_trunc_top
   import trunc_pkg::*;
#(
   // keep mask byte order, zero is little endian
   parameter bit BIGENDIAN = 1'b0
) (
   input  wire          axi4s_in,
   input  wire          rst_n,

   // stream in
   input  wire axis_beat_t  in_beat,
   input  wire          in_valid,
   output logic         in_ready,

   // stream out
   output axis_beat_t   out_beat,
   output logic         out_valid,
   input  wire          out_ready,

   // configuration port
   input  wire          wb_cyc,
   input  wire          wb_stb,
   input  wire          wb_we,
   input  wire wb_addr_t    wb_adr,
   input  wire wb_data_t    wb_dat_w,
   output wb_data_t     wb_dat_r,
   output logic         wb_ack
);

   // --------------------------------------------------
   // internal connections
   // --------------------------------------------------

   logic         trunc_enable;
   byte_len_t    trunc_length;
   logic         stats_clear;
   trunc_event_t trunc_event;
   stat_cnt_t    pkt_count;
   stat_cnt_t    trunc_count;
   stat_cnt_t    dropped_bytes;

   // stream path
   axis_trunc_core #(
      .BIGENDIAN    (BIGENDIAN)
   ) core0 (
      .axi4s_in     (axi4s_in),
      .rst_n        (rst_n),
      .in_beat      (in_beat),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .out_beat     (out_beat),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .trunc_enable (trunc_enable),
      .trunc_length (trunc_length),
      .trunc_event  (trunc_event)
   );

   // counters fed by the core's per-beat events
   trunc_stats stats0 (
      .axi4s_in      (axi4s_in),
      .rst_n         (rst_n),
      .trunc_event   (trunc_event),
      .stats_clear   (stats_clear),
      .pkt_count     (pkt_count),
      .trunc_count   (trunc_count),
      .dropped_bytes (dropped_bytes)
   );

   trunc_wb_regs regs0 (
      .axi4s_in      (axi4s_in),
      .rst_n         (rst_n),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_w      (wb_dat_w),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .pkt_count     (pkt_count),
      .trunc_count   (trunc_count),
      .dropped_bytes (dropped_bytes),
      .trunc_enable  (trunc_enable),
      .trunc_length  (trunc_length),
      .stats_clear   (stats_clear)
   );

endmodule

`default_nettype wire

// ==== logic/trunc_pkg.sv ====
/*
 * shared definitions for the AXI4-Stream packet truncator
 * holds the beat and event structs, the register map and
 * the Wishbone slave state encoding
 */

`default_nettype none

package trunc_pkg;

   // --------------------------------------------------
   // stream geometry
   // --------------------------------------------------

   // the data path is fixed at eight bytes per beat
   localparam int DATA_BYTES = 8;

   // a byte count or a byte limit within one packet
   typedef logic [15:0] byte_len_t;

   // one keep bit per data byte
   typedef logic [DATA_BYTES-1:0] keep_t;

   // width of each statistics counter
   typedef logic [31:0] stat_cnt_t;

   // one stream beat, sideband fields ride along untouched
   typedef struct packed {
      logic [DATA_BYTES*8-1:0] tdata;
      keep_t                   tkeep;
      logic                    tlast;
      logic [3:0]              tid;
      logic [3:0]              tdest;
      logic                    tuser;
   } axis_beat_t;

   // per-beat report from the core to the statistics unit
   // pkt_done and truncated are only ever high together with an accepted last beat
   typedef struct packed {
      logic      pkt_done;
      logic      truncated;
      byte_len_t dropped;
   } trunc_event_t;

   // --------------------------------------------------
   // Wishbone register map
   // --------------------------------------------------

   typedef logic [4:0]  wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // bit 0 is the truncation enable
   localparam wb_addr_t REG_CTRL    = 5'h00;
   // low 16 bits hold the byte limit, zero means no limit
   localparam wb_addr_t REG_LENGTH  = 5'h04;
   // read gives the packet count, any write clears all three counters
   localparam wb_addr_t REG_PKTS    = 5'h08;
   localparam wb_addr_t REG_TRUNCS  = 5'h0C;
   localparam wb_addr_t REG_DROPPED = 5'h10;

   // slave handshake states, ack is high only in WB_ACK
   typedef enum logic {
      WB_IDLE = 1'b0,
      WB_ACK  = 1'b1
   } wb_state_t;

endpackage

`default_nettype wire

// ==== logic/trunc_stats.sv ====
/*
 * statistics for the packet truncator
 * saturating counters of packets seen, packets truncated
 * and bytes dropped, cleared together on request
 */

`timescale 1ns/1ns
`default_nettype none

module trunc_stats
   import trunc_pkg::*;
(
   input  wire          axi4s_in,
   input  wire          rst_n,

   input  wire trunc_event_t trunc_event,
   input  wire          stats_clear,

   output stat_cnt_t    pkt_count,
   output stat_cnt_t    trunc_count,
   output stat_cnt_t    dropped_bytes
);

   // add with saturation at all ones
   function automatic stat_cnt_t sat_add(input stat_cnt_t acc, input stat_cnt_t inc);
      logic [$bits(stat_cnt_t):0] sum;
      sum = {1'b0, acc} + {1'b0, inc};
      return sum[$bits(stat_cnt_t)] ? '1 : sum[$bits(stat_cnt_t)-1:0];
   endfunction

   // --------------------------------------------------
   // counters
   // --------------------------------------------------

   // each event lands at the edge that accepts its beat
   // clear wins over an event arriving in the same cycle
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         pkt_count <= '0;
      end else if (stats_clear) begin
         pkt_count <= '0;
      end else if (trunc_event.pkt_done) begin
         pkt_count <= sat_add(pkt_count, stat_cnt_t'(1));
      end
   end

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         trunc_count <= '0;
      end else if (stats_clear) begin
         trunc_count <= '0;
      end else if (trunc_event.truncated) begin
         trunc_count <= sat_add(trunc_count, stat_cnt_t'(1));
      end
   end

   // dropped bytes accumulate beat by beat, not once per packet
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         dropped_bytes <= '0;
      end else if (stats_clear) begin
         dropped_bytes <= '0;
      end else if (trunc_event.dropped != '0) begin
         dropped_bytes <= sat_add(dropped_bytes, stat_cnt_t'(trunc_event.dropped));
      end
   end

endmodule

`default_nettype wire

// ==== logic/trunc_wb_regs.sv ====
/*
 * Wishbone classic register slave for the truncator
 * holds the enable bit and the byte limit, returns the
 * statistics counters and acks every access after one cycle
 */

`timescale 1ns/1ns
`default_nettype none

module trunc_wb_regs
   import trunc_pkg::*;
(
   input  wire          axi4s_in,
   input  wire          rst_n,

   input  wire          wb_cyc,
   input  wire          wb_stb,
   input  wire          wb_we,
   input  wire wb_addr_t    wb_adr,
   input  wire wb_data_t    wb_dat_w,
   output wb_data_t     wb_dat_r,
   output logic         wb_ack,

   input  wire stat_cnt_t   pkt_count,
   input  wire stat_cnt_t   trunc_count,
   input  wire stat_cnt_t   dropped_bytes,

   output logic         trunc_enable,
   output byte_len_t    trunc_length,
   output logic         stats_clear
);

   wb_state_t state;
   // a new request, only taken while idle so each cycle is served once
   logic      wb_req;
   wb_data_t  rd_data;

   assign wb_req = wb_cyc && wb_stb && (state == WB_IDLE);
   assign wb_ack = (state == WB_ACK);

   // the counter clear acts on the same edge that raises ack
   assign stats_clear = wb_req && wb_we && (wb_adr == REG_PKTS);

   // --------------------------------------------------
   // read multiplexer
   // --------------------------------------------------

   always_comb begin
      case (wb_adr)
         REG_CTRL:    rd_data = {31'b0, trunc_enable};
         REG_LENGTH:  rd_data = {16'b0, trunc_length};
         REG_PKTS:    rd_data = pkt_count;
         REG_TRUNCS:  rd_data = trunc_count;
         REG_DROPPED: rd_data = dropped_bytes;
         // unmapped addresses read as zero
         default:     rd_data = '0;
      endcase
   end

   // --------------------------------------------------
   // handshake FSM and register writes
   // --------------------------------------------------

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         state    <= WB_IDLE;
         wb_dat_r <= '0;
      end else begin
         case (state)
            WB_IDLE: begin
               if (wb_req) begin
                  state    <= WB_ACK;
                  // sample read data now so it is stable for the whole ack cycle
                  wb_dat_r <= rd_data;
               end
            end
            WB_ACK: begin
               // the master drops stb on the edge that ends the ack cycle
               state <= WB_IDLE;
            end
            default: state <= WB_IDLE;
         endcase
      end
   end

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         trunc_enable <= 1'b0;
         trunc_length <= '0;
      end else if (wb_req && wb_we) begin
         if (wb_adr == REG_CTRL) begin
            trunc_enable <= wb_dat_w[0];
         end
         // the core only picks this up on the next first beat
         if (wb_adr == REG_LENGTH) begin
            trunc_length <= wb_dat_w[15:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== verification/axis_trunc_assertions.sv ====
/*
 * protocol assertions for the truncation core
 * reset quiet output, contiguous keep, stable stalled beats
 * and clean packet boundaries on the output stream
 */

`timescale 1ns/1ns
`default_nettype none

module axis_trunc_assertions
   import trunc_pkg::*;
(
   input  wire             axi4s_in,
   input  wire             rst_n,
   input  wire axis_beat_t in_beat,
   input  wire             in_valid,
   input  wire             in_ready,
   input  wire axis_beat_t out_beat,
   input  wire             out_valid,
   input  wire             out_ready
);

   // high while the next input beat starts a packet
   logic in_first;
   // high when the last output transfer carried tlast
   logic out_after_last;

   // a single run of ones, found by filling the low zeros and adding one
   function automatic logic keep_contiguous(input keep_t keep);
      keep_t filled;
      keep_t past_run;
      filled   = keep | (keep - keep_t'(1));
      past_run = filled + keep_t'(1);
      return (past_run & keep) == '0;
   endfunction

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         in_first       <= 1'b1;
         out_after_last <= 1'b0;
      end else begin
         if (in_valid && in_ready) begin
            in_first <= in_beat.tlast;
         end
         if (out_valid && out_ready) begin
            out_after_last <= out_beat.tlast;
         end
      end
   end

   // --------------------------------------------------
   // properties
   // --------------------------------------------------

   reset_quiet: assert property (@(posedge axi4s_in) !rst_n |-> !out_valid)
      else $error("out_valid high while in reset");

   keep_shape: assert property (@(posedge axi4s_in) disable iff (!rst_n)
      out_valid |-> keep_contiguous(out_beat.tkeep))
      else $error("output keep mask %h is not contiguous", out_beat.tkeep);

   // a stalled beat must not change until it is taken
   stall_stable: assert property (@(posedge axi4s_in) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_beat))
      else $error("out_beat changed while stalled");

   // after an output tlast the next output beat must open a new input packet
   packet_start: assert property (@(posedge axi4s_in) disable iff (!rst_n)
      out_valid && out_ready && out_after_last |-> in_first)
      else $error("output beat after tlast is not an input first beat");

endmodule

bind axis_trunc_core axis_trunc_assertions chk0 (
   .axi4s_in  (axi4s_in),
   .rst_n     (rst_n),
   .in_beat   (in_beat),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out_beat  (out_beat),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

`default_nettype wire

// ==== verification/axis_trunc_tb.sv ====
/*
 * directed testbench for the AXI4-Stream packet truncator
 * drives packets and Wishbone accesses, predicts the output
 * from the truncation rule and compares beat by beat
 */

`timescale 1ns/1ns
`default_nettype none

module axis_trunc_tb
   import trunc_pkg::*;
();

   localparam int STREAM_TIMEOUT = 2000;
   localparam int WB_TIMEOUT     = 10;

   wire        axi4s_in;
   wire        rst_n;
   axis_beat_t in_beat;
   logic       in_valid;
   logic       in_ready;
   axis_beat_t out_beat;
   logic       out_valid;
   logic       out_ready;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   wb_addr_t   wb_adr;
   wb_data_t   wb_dat_w;
   wb_data_t   wb_dat_r;
   logic       wb_ack;

   // stimulus, expected and received beats of the running test
   axis_beat_t tx_q[$];
   axis_beat_t exp_q[$];
   axis_beat_t rx_q[$];
   // one flag per input beat, set when the beat lies inside the limit
   logic       tx_pass_q[$];

   logic [15:0] lfsr_state;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          beats_accepted;
   int          pkt_id;
   // configuration the model assumes for packets built next
   logic        model_enable;
   int          model_length;
   int          exp_pkts;
   int          exp_truncs;
   int          exp_dropped;

   tb_clk_gen clk0 (
      .axi4s_in (axi4s_in),
      .rst_n    (rst_n)
   );

   axis_trunc_top #(
      .BIGENDIAN (1'b0)
   ) dut0 (
      .axi4s_in  (axi4s_in),
      .rst_n     (rst_n),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack)
   );

   // output monitor, every transfer lands in rx_q
   always @(posedge axi4s_in) begin
      if (rst_n && out_valid && out_ready) begin
         rx_q.push_back(out_beat);
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         value      = {value[30:0], fb};
      end
      return value;
   endfunction

   // little endian keep, the first n bytes sit in the low bits
   function automatic keep_t low_keep(input int n);
      keep_t keep;
      keep = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         keep[i] = (i < n);
      end
      return keep;
   endfunction

   // bytes outside the keep mask carry no meaning
   function automatic logic [63:0] mask_data(input logic [63:0] data, input keep_t keep);
      logic [63:0] masked;
      masked = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         if (keep[i]) begin
            masked[i*8 +: 8] = data[i*8 +: 8];
         end
      end
      return masked;
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   // --------------------------------------------------
   // Wishbone master
   // --------------------------------------------------

   task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                            output wb_data_t rdata);
      int waits;
      waits = 0;
      rdata = '0;
      @(negedge axi4s_in);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      @(posedge axi4s_in);
      while (!wb_ack && waits < WB_TIMEOUT) begin
         waits++;
         @(posedge axi4s_in);
      end
      if (!wb_ack) begin
         $display("timeout: no Wishbone ack for address %h", adr);
         errors++;
         test_errors++;
      end else begin
         rdata = wb_dat_r;
         // ack comes exactly one cycle after the request
         check("wb_ack delay", waits, 1);
      end
      @(negedge axi4s_in);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      // ack must drop after a single cycle
      @(posedge axi4s_in);
      check("wb_ack", wb_ack, 1'b0);
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
      wb_data_t unused;
      wb_access(1'b1, adr, data, unused);
   endtask

   task automatic set_limit(input logic enable, input int length);
      wb_write(REG_CTRL, {31'b0, enable});
      wb_write(REG_LENGTH, length);
      model_enable = enable;
      model_length = length;
   endtask

   // --------------------------------------------------
   // stream driver and reference model
   // --------------------------------------------------

   // queues one input packet and the output that the truncation rule predicts
   task automatic add_packet(input int len);
      axis_beat_t beat;
      int         nbeats;
      int         out_len;
      nbeats  = (len + DATA_BYTES - 1) / DATA_BYTES;
      out_len = len;
      if (model_enable && model_length > 0 && len > model_length) begin
         out_len = model_length;
      end
      pkt_id++;
      for (int b = 0; b < nbeats; b++) begin
         beat.tdata[63:32] = lfsr_bits(32);
         beat.tdata[31:0]  = lfsr_bits(32);
         beat.tkeep = low_keep(len - b * DATA_BYTES);
         beat.tlast = (b == nbeats - 1);
         beat.tid   = 4'(pkt_id);
         beat.tdest = 4'(lfsr_bits(4));
         beat.tuser = 1'(lfsr_bits(1));
         tx_q.push_back(beat);
         tx_pass_q.push_back(b * DATA_BYTES < out_len);
         // beats holding any of the first out_len bytes reach the output
         if (b * DATA_BYTES < out_len) begin
            beat.tkeep = low_keep(out_len - b * DATA_BYTES);
            beat.tlast = ((b + 1) * DATA_BYTES >= out_len);
            exp_q.push_back(beat);
         end
      end
      exp_pkts++;
      if (out_len < len) begin
         exp_truncs++;
         exp_dropped += len - out_len;
      end
   endtask

   // sends tx_q, then compares every received beat with exp_q
   task automatic run_stream(input logic stall);
      int idx;
      int cycles;
      idx    = 0;
      cycles = 0;
      while (idx < tx_q.size() && cycles < STREAM_TIMEOUT) begin
         @(negedge axi4s_in);
         in_beat   = tx_q[idx];
         in_valid  = 1'b1;
         // with stalls on, the sink is ready three cycles out of four
         out_ready = stall ? (lfsr_bits(2) != 2'b00) : 1'b1;
         @(posedge axi4s_in);
         // a beat beyond the limit is taken whatever the sink does
         check("out_valid", out_valid, tx_pass_q[idx]);
         check("in_ready", in_ready, tx_pass_q[idx] ? out_ready : 1'b1);
         if (in_ready) begin
            idx++;
            beats_accepted++;
         end
         cycles++;
      end
      if (idx < tx_q.size()) begin
         $display("timeout: input beat %0d of %0d was never accepted", idx, tx_q.size());
         errors++;
         test_errors++;
      end
      @(negedge axi4s_in);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      cycles    = 0;
      while (rx_q.size() < exp_q.size() && cycles < STREAM_TIMEOUT) begin
         @(negedge axi4s_in);
         cycles++;
      end
      if (rx_q.size() < exp_q.size()) begin
         $display("timeout: only %0d of %0d output beats arrived", rx_q.size(), exp_q.size());
         errors++;
         test_errors++;
      end
      check("output beat count", rx_q.size(), exp_q.size());
      for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
         check("out_beat.tdata", mask_data(rx_q[i].tdata, exp_q[i].tkeep),
               mask_data(exp_q[i].tdata, exp_q[i].tkeep));
         check("out_beat.tkeep", rx_q[i].tkeep, exp_q[i].tkeep);
         check("out_beat.tlast", rx_q[i].tlast, exp_q[i].tlast);
         check("out_beat.tid", rx_q[i].tid, exp_q[i].tid);
         check("out_beat.tdest", rx_q[i].tdest, exp_q[i].tdest);
         check("out_beat.tuser", rx_q[i].tuser, exp_q[i].tuser);
      end
      tx_q.delete();
      tx_pass_q.delete();
      exp_q.delete();
      rx_q.delete();
   endtask

   // --------------------------------------------------
   // directed tests
   // --------------------------------------------------

   task automatic test_registers();
      wb_data_t rd;
      wb_access(1'b0, REG_CTRL, '0, rd);
      check("wb_dat_r REG_CTRL", rd, 0);
      wb_access(1'b0, REG_LENGTH, '0, rd);
      check("wb_dat_r REG_LENGTH", rd, 0);
      wb_access(1'b0, REG_PKTS, '0, rd);
      check("wb_dat_r REG_PKTS", rd, 0);
      wb_access(1'b0, REG_TRUNCS, '0, rd);
      check("wb_dat_r REG_TRUNCS", rd, 0);
      wb_access(1'b0, REG_DROPPED, '0, rd);
      check("wb_dat_r REG_DROPPED", rd, 0);
      wb_write(REG_CTRL, 32'h0000_0001);
      wb_access(1'b0, REG_CTRL, '0, rd);
      check("wb_dat_r REG_CTRL", rd, 1);
      wb_write(REG_LENGTH, 32'h0000_1234);
      wb_access(1'b0, REG_LENGTH, '0, rd);
      check("wb_dat_r REG_LENGTH", rd, 32'h1234);
      // an unmapped address reads zero
      wb_access(1'b0, 5'h14, '0, rd);
      check("wb_dat_r unmapped", rd, 0);
      set_limit(1'b0, 0);
      finish_test("reset and registers");
   endtask

   task automatic test_pass_through();
      // the limit is ignored while enable is off
      set_limit(1'b0, 5);
      for (int i = 0; i < 4; i++) begin
         add_packet(1 + lfsr_bits(6));
      end
      run_stream(1'b0);
      set_limit(1'b1, 0);
      for (int i = 0; i < 4; i++) begin
         add_packet(1 + lfsr_bits(6));
      end
      run_stream(1'b0);
      finish_test("pass-through");
   endtask

   task automatic test_truncation();
      int limits[3];
      limits = '{13, 8, 1};
      foreach (limits[k]) begin
         set_limit(1'b1, limits[k]);
         if (limits[k] > 1) begin
            add_packet(limits[k] - 1);
         end
         add_packet(limits[k]);
         add_packet(limits[k] + 1);
         add_packet(limits[k] + 9 + lfsr_bits(5));
         run_stream(1'b0);
      end
      finish_test("truncation");
   endtask

   task automatic test_back_pressure();
      set_limit(1'b1, 11);
      for (int i = 0; i < 6; i++) begin
         add_packet(12 + lfsr_bits(5));
      end
      run_stream(1'b1);
      finish_test("back-pressure");
   endtask

   task automatic test_statistics();
      wb_data_t rd;
      wb_write(REG_PKTS, '0);
      exp_pkts    = 0;
      exp_truncs  = 0;
      exp_dropped = 0;
      set_limit(1'b1, 10);
      for (int i = 0; i < 8; i++) begin
         add_packet(1 + lfsr_bits(6));
      end
      run_stream(1'b1);
      wb_access(1'b0, REG_PKTS, '0, rd);
      check("pkt_count", rd, exp_pkts);
      wb_access(1'b0, REG_TRUNCS, '0, rd);
      check("trunc_count", rd, exp_truncs);
      wb_access(1'b0, REG_DROPPED, '0, rd);
      check("dropped_bytes", rd, exp_dropped);
      // any write to the packet counter clears all three
      wb_write(REG_PKTS, 32'hdead_beef);
      wb_access(1'b0, REG_PKTS, '0, rd);
      check("pkt_count", rd, 0);
      wb_access(1'b0, REG_TRUNCS, '0, rd);
      check("trunc_count", rd, 0);
      wb_access(1'b0, REG_DROPPED, '0, rd);
      check("dropped_bytes", rd, 0);
      finish_test("statistics");
   endtask

   task automatic test_limit_change();
      int waits;
      set_limit(1'b1, 13);
      add_packet(40);
      // the second packet must see the limit written during the first
      // the new limit reaches past the tail beats of the first packet
      model_length = 35;
      add_packet(40);
      beats_accepted = 0;
      fork
         run_stream(1'b0);
         begin
            waits = 0;
            while (beats_accepted < 1 && waits < STREAM_TIMEOUT) begin
               @(negedge axi4s_in);
               waits++;
            end
            if (beats_accepted < 1) begin
               $display("timeout: first beat never accepted before the limit change");
               errors++;
               test_errors++;
            end
            wb_write(REG_LENGTH, 35);
         end
      join
      finish_test("limit change mid-packet");
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------

   initial begin
      int waits;
      in_beat        = '0;
      in_valid       = 1'b0;
      out_ready      = 1'b1;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      wb_we          = 1'b0;
      wb_adr         = '0;
      wb_dat_w       = '0;
      lfsr_state     = 16'd43;
      errors         = 0;
      test_errors    = 0;
      tests_run      = 0;
      tests_failed   = 0;
      beats_accepted = 0;
      pkt_id         = 0;
      model_enable   = 1'b0;
      model_length   = 0;
      exp_pkts       = 0;
      exp_truncs     = 0;
      exp_dropped    = 0;
      waits          = 0;
      while (rst_n !== 1'b1 && waits < 20) begin
         @(negedge axi4s_in);
         waits++;
      end
      if (rst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         errors++;
      end
      test_registers();
      test_pass_through();
      test_truncation();
      test_back_pressure();
      test_statistics();
      test_limit_change();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
/*
 * clock and reset source for the truncator testbench
 * free running clock, reset held low for the first cycles
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic axi4s_in,
   output logic rst_n
);

   initial begin
      axi4s_in = 1'b0;
      forever #(PERIOD / 2) axi4s_in = ~axi4s_in;
   end

   // reset is released on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge axi4s_in);
      @(negedge axi4s_in);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire
